/* testbench/reorderBuffer_trace.txt */
# in:  dispMask dispBase preMask wb0Valid wb0SqN wb0Flags wb1Valid wb1SqN wb1Flags misTaken misSqN
# out: comMask comBase branchMask exceptMask flush trap trapSqN halt curSqN maxSqN (all hex)
f 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 00 0f
0 00 0 1 03 0 1 02 0 0 00 0 00 0 0 0 0 00 0 00 0f
0 00 0 1 01 0 0 00 0 0 00 0 00 0 0 0 0 00 0 00 0f
0 00 0 1 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 00 0f
f 04 3 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 00 0f
0 00 0 1 06 1 1 07 1 0 00 f 00 0 0 0 0 00 0 04 13
0 00 0 0 00 0 0 00 0 0 00 3 04 0 0 0 0 00 0 06 15
0 00 0 0 00 0 0 00 0 0 00 1 06 1 0 0 0 00 0 07 16
f 08 0 0 00 0 0 00 0 0 00 1 07 1 0 0 0 00 0 08 17
0 00 0 1 08 0 1 09 2 0 00 0 00 0 0 0 0 00 0 08 17
0 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 08 17
0 00 0 0 00 0 0 00 0 0 00 3 08 0 2 0 0 00 0 0a 19
0 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 1 09 0 0a 19
0 00 0 1 0a 0 1 0b 0 0 00 0 00 0 0 0 0 00 0 0a 19
f 0a 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 0a 19
0 00 0 1 0a 3 1 0b 0 0 00 0 00 0 0 0 0 00 0 0a 19
0 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 0a 19
0 00 0 0 00 0 0 00 0 0 00 1 0a 0 0 0 0 00 0 0b 1a
0 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 1 0a 1 0b 1a
f 0b 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 0b 1a
f 0f 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 0b 1a
0 00 0 0 00 0 0 00 0 1 10 0 00 0 0 0 0 00 0 0b 1a
0 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 0b 1a
0 00 0 0 00 0 0 00 0 0 00 f 0b 0 0 1 0 00 0 0b 1a
f 11 f 0 00 0 0 00 0 0 00 3 0f 0 0 1 0 00 0 0b 1a
0 00 0 1 0b 0 1 0c 0 0 00 0 00 0 0 0 0 00 0 0b 1a
0 00 0 1 0d 0 1 0e 0 0 00 0 00 0 0 0 0 00 0 0b 1a
0 00 0 1 0f 0 1 10 1 0 00 3 0b 0 0 0 0 00 0 0d 1c
0 00 0 0 00 0 0 00 0 0 00 3 0d 0 0 0 0 00 0 0f 1e
0 00 0 0 00 0 0 00 0 0 00 f 0f 2 0 0 0 00 0 13 02
f 15 0 0 00 0 0 00 0 0 00 3 13 0 0 0 0 00 0 15 04
0 00 0 1 17 0 1 18 0 1 16 0 00 0 0 0 0 00 0 15 04
0 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 15 04
f 17 f 1 15 0 1 16 1 0 00 3 15 0 0 1 0 00 0 15 04
0 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 15 04
0 00 0 0 00 0 0 00 0 0 00 f 15 2 0 0 0 00 0 19 08
0 00 0 0 00 0 0 00 0 0 00 3 19 0 0 0 0 00 0 1b 0a
0 00 0 0 00 0 0 00 0 0 00 0 00 0 0 0 0 00 0 1b 0a

/* sim.f */
hw/robPkg.sv
hw/robEntryFile.sv
hw/commitWindow.sv
hw/rollbackReplay.sv
hw/reorderBuffer.sv
testbench/reorderBuffer_assert.sv
testbench/reorderBufferTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= reorderBufferTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/reorderBufferTb.sv */
`default_nettype none
`timescale 1ns/1ns

module reorderBufferTb;

    localparam int LENGTH = 16;
    localparam int WIDTH = 4;
    localparam int WIDTH_WB = 2;
    localparam int SQN_W = robPkg::sqnWidth(LENGTH);
    localparam int IDX_W = $clog2(LENGTH);
    localparam int FLAG_W = robPkg::FLAG_W;
    localparam int NAME_W = robPkg::NAME_W;
    localparam int TAG_W = robPkg::TAG_W;
    localparam string TRACE_PATH = "testbench/reorderBuffer_trace.txt";
    localparam int NFIELDS = 21;
    localparam int MAX_LINES = 64;

    // Trace columns
    localparam int F_DM = 0;
    localparam int F_DB = 1;
    localparam int F_PM = 2;
    localparam int F_WB = 3;
    localparam int F_MT = 9;
    localparam int F_MS = 10;
    localparam int F_CM = 11;
    localparam int F_CB = 12;
    localparam int F_BR = 13;
    localparam int F_EX = 14;
    localparam int F_FL = 15;
    localparam int F_TT = 16;
    localparam int F_TS = 17;
    localparam int F_HT = 18;
    localparam int F_CUR = 19;
    localparam int F_MAX = 20;

    logic clk;
    logic rst;
    logic dispValid [WIDTH];
    logic [SQN_W-1:0] dispSqN [WIDTH];
    logic [NAME_W-1:0] dispName [WIDTH];
    logic [TAG_W-1:0] dispTag [WIDTH];
    logic dispPreExec [WIDTH];
    logic wbValid [WIDTH_WB];
    logic [SQN_W-1:0] wbSqN [WIDTH_WB];
    logic [FLAG_W-1:0] wbFlags [WIDTH_WB];
    logic mispredTaken;
    logic [SQN_W-1:0] mispredSqN;
    logic [SQN_W-1:0] curSqN;
    logic [SQN_W-1:0] maxSqN;
    logic comValid [WIDTH];
    logic [SQN_W-1:0] comSqN [WIDTH];
    logic [NAME_W-1:0] comName [WIDTH];
    logic [TAG_W-1:0] comTag [WIDTH];
    logic comIsBranch [WIDTH];
    logic mispredFlush;
    logic trapTaken;
    logic [SQN_W-1:0] trapSqN;
    logic halt;

    int trace [MAX_LINES][NFIELDS];
    int lineCount = 0;
    int cycleLimit = 0;
    int cycleCount = 0;

    reorderBuffer #(
        .LENGTH(LENGTH),
        .WIDTH(WIDTH),
        .WIDTH_WB(WIDTH_WB)
    ) reorderBuffer_i (
        .clk(clk),
        .rst(rst),
        .dispValid(dispValid),
        .dispSqN(dispSqN),
        .dispName(dispName),
        .dispTag(dispTag),
        .dispPreExec(dispPreExec),
        .wbValid(wbValid),
        .wbSqN(wbSqN),
        .wbFlags(wbFlags),
        .mispredTaken(mispredTaken),
        .mispredSqN(mispredSqN),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .comValid(comValid),
        .comSqN(comSqN),
        .comName(comName),
        .comTag(comTag),
        .comIsBranch(comIsBranch),
        .mispredFlush(mispredFlush),
        .trapTaken(trapTaken),
        .trapSqN(trapSqN),
        .halt(halt)
    );

    // Register name and tag of an op follow from its sqN
    function automatic logic [NAME_W-1:0] nameOf(input logic [SQN_W-1:0] s);
        return NAME_W'(s[IDX_W-1:0]) + NAME_W'(1);
    endfunction

    function automatic logic [TAG_W-1:0] tagOf(input logic [SQN_W-1:0] s);
        return TAG_W'(s) + TAG_W'(32);
    endfunction

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input int r, input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
        failNow($sformatf("[FAIL] %s got 0x%0h expected 0x%0h at trace line %0d",
                          sig, got, exp, r));
    endtask

    task automatic checkCommitLane(input int r, input int lane, input logic gotValid,
                                   input logic [SQN_W-1:0] gotSqN,
                                   input logic [NAME_W-1:0] gotName,
                                   input logic [TAG_W-1:0] gotTag, input logic gotBranch,
                                   input logic expValid, input logic [SQN_W-1:0] expSqN,
                                   input logic [NAME_W-1:0] expName,
                                   input logic [TAG_W-1:0] expTag, input logic expBranch);
        if (gotValid !== expValid)
            reportMismatch(r, $sformatf("comValid[%0d]", lane), 32'(gotValid), 32'(expValid));
        if (expValid) begin
            if (gotSqN !== expSqN)
                reportMismatch(r, $sformatf("comSqN[%0d]", lane), 32'(gotSqN), 32'(expSqN));
            if (gotName !== expName)
                reportMismatch(r, $sformatf("comName[%0d]", lane), 32'(gotName), 32'(expName));
            if (gotTag !== expTag)
                reportMismatch(r, $sformatf("comTag[%0d]", lane), 32'(gotTag), 32'(expTag));
            if (gotBranch !== expBranch)
                reportMismatch(r, $sformatf("comIsBranch[%0d]", lane), 32'(gotBranch),
                               32'(expBranch));
        end
    endtask

    task automatic checkReplay(input int r, input logic gotFlush, input logic expFlush);
        if (gotFlush !== expFlush)
            reportMismatch(r, "mispredFlush", 32'(gotFlush), 32'(expFlush));
    endtask

    task automatic checkTrap(input int r, input logic gotTaken, input logic [SQN_W-1:0] gotSqN,
                             input logic gotHalt, input logic expTaken,
                             input logic [SQN_W-1:0] expSqN, input logic expHalt);
        if (gotTaken !== expTaken)
            reportMismatch(r, "trapTaken", 32'(gotTaken), 32'(expTaken));
        if (gotHalt !== expHalt)
            reportMismatch(r, "halt", 32'(gotHalt), 32'(expHalt));
        if (expTaken && gotSqN !== expSqN)
            reportMismatch(r, "trapSqN", 32'(gotSqN), 32'(expSqN));
    endtask

    task automatic checkCounters(input int r, input logic [SQN_W-1:0] gotCur,
                                 input logic [SQN_W-1:0] gotMax,
                                 input logic [SQN_W-1:0] expCur,
                                 input logic [SQN_W-1:0] expMax);
        if (gotCur !== expCur)
            reportMismatch(r, "curSqN", 32'(gotCur), 32'(expCur));
        if (gotMax !== expMax)
            reportMismatch(r, "maxSqN", 32'(gotMax), 32'(expMax));
    endtask

    task automatic readTrace();
        int fd;
        int n;
        string line;
        int v [NFIELDS];
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0)
            failNow("Could not open the trace file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                        v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20]);
            if (n != NFIELDS)
                failNow($sformatf("Trace line %0d has %0d fields instead of %0d",
                                  lineCount, n, NFIELDS));
            if (lineCount >= MAX_LINES)
                failNow("The trace holds more lines than the testbench can store");
            for (int k = 0; k < NFIELDS; k++)
                trace[lineCount][k] = v[k];
            lineCount++;
        end
        $fclose(fd);
        // Reset cycles plus the trace plus some slack
        cycleLimit = lineCount + 20 + 2;
    endtask

    task automatic driveInputs(input int r);
        logic [SQN_W-1:0] s;
        for (int i = 0; i < WIDTH; i++) begin
            s = SQN_W'(trace[r][F_DB] + i);
            dispValid[i] = trace[r][F_DM][i];
            dispSqN[i] = s;
            dispName[i] = nameOf(s);
            dispTag[i] = tagOf(s);
            dispPreExec[i] = trace[r][F_PM][i];
        end
        for (int j = 0; j < WIDTH_WB; j++) begin
            wbValid[j] = trace[r][F_WB + 3 * j][0];
            wbSqN[j] = SQN_W'(trace[r][F_WB + 3 * j + 1]);
            wbFlags[j] = FLAG_W'(trace[r][F_WB + 3 * j + 2]);
        end
        mispredTaken = trace[r][F_MT][0];
        mispredSqN = SQN_W'(trace[r][F_MS]);
    endtask

    task automatic checkOutputs(input int r);
        logic [SQN_W-1:0] s;
        logic [NAME_W-1:0] expName;
        for (int i = 0; i < WIDTH; i++) begin
            s = SQN_W'(trace[r][F_CB] + i);
            // Excepting op retires into the discard register
            expName = trace[r][F_EX][i] ? '0 : nameOf(s);
            checkCommitLane(r, i, comValid[i], comSqN[i], comName[i], comTag[i],
                            comIsBranch[i], trace[r][F_CM][i], s, expName, tagOf(s),
                            trace[r][F_BR][i]);
        end
        checkReplay(r, mispredFlush, trace[r][F_FL][0]);
        checkTrap(r, trapTaken, trapSqN, halt, trace[r][F_TT][0], SQN_W'(trace[r][F_TS]),
                  trace[r][F_HT][0]);
        checkCounters(r, curSqN, maxSqN, SQN_W'(trace[r][F_CUR]), SQN_W'(trace[r][F_MAX]));
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
            failNow("Timeout: the trace did not complete within the cycle limit");
    end

    initial begin
        rst = 1'b1;
        for (int i = 0; i < WIDTH; i++) begin
            dispValid[i] = 1'b0;
            dispSqN[i] = '0;
            dispName[i] = '0;
            dispTag[i] = '0;
            dispPreExec[i] = 1'b0;
        end
        for (int j = 0; j < WIDTH_WB; j++) begin
            wbValid[j] = 1'b0;
            wbSqN[j] = '0;
            wbFlags[j] = '0;
        end
        mispredTaken = 1'b0;
        mispredSqN = '0;
        readTrace();
        repeat (2) @(posedge clk);
        // Each trace line drives one cycle and checks it just before the next edge
        for (int r = 0; r < lineCount; r++) begin
            #5;
            rst = 1'b0;
            driveInputs(r);
            #90;
            checkOutputs(r);
            @(posedge clk);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/reorderBuffer_assert.sv */
`default_nettype none
`timescale 1ns/1ns

module reorderBufferAssert #(
    parameter int WIDTH = 4
) (
    input logic clk,
    input logic rst,
    input logic mispredTaken,
    input logic comValid [WIDTH],
    input logic trapTaken,
    input logic halt
);

    logic [WIDTH-1:0] comMask;

    always_comb begin
        for (int i = 0; i < WIDTH; i++)
            comMask[i] = comValid[i];
    end

    trapPulse: assert property (@(posedge clk) disable iff (rst) trapTaken |=> !trapTaken)
        else $error("trapTaken held longer than one cycle");

    haltPulse: assert property (@(posedge clk) disable iff (rst) halt |=> !halt)
        else $error("halt held longer than one cycle");

    haltWithTrap: assert property (@(posedge clk) disable iff (rst) halt |-> trapTaken)
        else $error("halt without trapTaken");

    // Squash cycle carries no lanes
    quietAfterMispred: assert property (@(posedge clk) disable iff (rst)
        mispredTaken |=> comMask == '0)
        else $error("commit lane valid right after a mispredict");

    lanePrefix: assert property (@(posedge clk) disable iff (rst)
        (comMask & (comMask + WIDTH'(1))) == '0)
        else $error("commit lanes are not a prefix");

endmodule

bind reorderBuffer reorderBufferAssert #(
    .WIDTH(WIDTH)
) reorderBufferAssert_i (
    .clk(clk),
    .rst(rst),
    .mispredTaken(mispredTaken),
    .comValid(comValid),
    .trapTaken(trapTaken),
    .halt(halt)
);

`default_nettype wire

/* hw/reorderBuffer.sv */
`default_nettype none
`timescale 1ns/1ns

module reorderBuffer #(
    parameter int LENGTH = 16,
    parameter int WIDTH = 4,
    parameter int WIDTH_WB = 2,
    localparam int SQN_W = robPkg::sqnWidth(LENGTH),
    localparam int IDX_W = $clog2(LENGTH)
) (
    input logic clk,
    input logic rst,
    input logic dispValid [WIDTH],
    input logic [SQN_W-1:0] dispSqN [WIDTH],
    input logic [robPkg::NAME_W-1:0] dispName [WIDTH],
    input logic [robPkg::TAG_W-1:0] dispTag [WIDTH],
    input logic dispPreExec [WIDTH],
    input logic wbValid [WIDTH_WB],
    input logic [SQN_W-1:0] wbSqN [WIDTH_WB],
    input logic [robPkg::FLAG_W-1:0] wbFlags [WIDTH_WB],
    input logic mispredTaken,
    input logic [SQN_W-1:0] mispredSqN,
    output logic [SQN_W-1:0] curSqN,
    output logic [SQN_W-1:0] maxSqN,
    output logic comValid [WIDTH],
    output logic [SQN_W-1:0] comSqN [WIDTH],
    output logic [robPkg::NAME_W-1:0] comName [WIDTH],
    output logic [robPkg::TAG_W-1:0] comTag [WIDTH],
    output logic comIsBranch [WIDTH],
    output logic mispredFlush,
    output logic trapTaken,
    output logic [SQN_W-1:0] trapSqN,
    output logic halt
);

    logic headValid [WIDTH];
    logic headExecuted [WIDTH];
    logic [robPkg::FLAG_W-1:0] headFlags [WIDTH];
    logic [robPkg::NAME_W-1:0] headName [WIDTH];
    logic [robPkg::TAG_W-1:0] headTag [WIDTH];
    logic [SQN_W-1:0] headSqN;
    logic retireMask [WIDTH];

    logic replayActive;
    logic [IDX_W-1:0] replayBase;
    logic replayLaneValid [WIDTH];
    logic [SQN_W-1:0] replaySqN [WIDTH];
    logic [robPkg::NAME_W-1:0] entReplayName [WIDTH];
    logic [robPkg::TAG_W-1:0] entReplayTag [WIDTH];
    logic [robPkg::NAME_W-1:0] replayName [WIDTH];
    logic [robPkg::TAG_W-1:0] replayTag [WIDTH];

    robEntryFile #(
        .LENGTH(LENGTH),
        .WIDTH(WIDTH),
        .WIDTH_WB(WIDTH_WB)
    ) entryFile_i (
        .clk(clk),
        .rst(rst),
        .dispValid(dispValid),
        .dispSqN(dispSqN),
        .dispName(dispName),
        .dispTag(dispTag),
        .dispPreExec(dispPreExec),
        .wbValid(wbValid),
        .wbSqN(wbSqN),
        .wbFlags(wbFlags),
        .mispredTaken(mispredTaken),
        .mispredSqN(mispredSqN),
        .trapTaken(trapTaken),
        .trapSqN(trapSqN),
        .headSqN(headSqN),
        .replayBase(replayBase),
        .retireMask(retireMask),
        .headValid(headValid),
        .headExecuted(headExecuted),
        .headFlags(headFlags),
        .headName(headName),
        .headTag(headTag),
        .replayName(entReplayName),
        .replayTag(entReplayTag)
    );

    commitWindow #(
        .LENGTH(LENGTH),
        .WIDTH(WIDTH)
    ) commitWindow_i (
        .clk(clk),
        .rst(rst),
        .headValid(headValid),
        .headExecuted(headExecuted),
        .headFlags(headFlags),
        .headName(headName),
        .headTag(headTag),
        .mispredTaken(mispredTaken),
        .replayActive(replayActive),
        .replayLaneValid(replayLaneValid),
        .replayName(replayName),
        .replayTag(replayTag),
        .replaySqN(replaySqN),
        .headSqN(headSqN),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .retireMask(retireMask),
        .comValid(comValid),
        .comSqN(comSqN),
        .comName(comName),
        .comTag(comTag),
        .comIsBranch(comIsBranch),
        .mispredFlush(mispredFlush),
        .trapTaken(trapTaken),
        .trapSqN(trapSqN),
        .halt(halt)
    );

    rollbackReplay #(
        .LENGTH(LENGTH),
        .WIDTH(WIDTH)
    ) rollbackReplay_i (
        .clk(clk),
        .rst(rst),
        .mispredTaken(mispredTaken),
        .mispredSqN(mispredSqN),
        .headSqN(headSqN),
        .replayName(entReplayName),
        .replayTag(entReplayTag),
        .replayActive(replayActive),
        .replayBase(replayBase),
        .replayLaneValid(replayLaneValid),
        .replaySqN(replaySqN),
        .replayNameOut(replayName),
        .replayTagOut(replayTag)
    );

endmodule

`default_nettype wire

/* hw/rollbackReplay.sv */
`default_nettype none
`timescale 1ns/1ns

module rollbackReplay #(
    parameter int LENGTH = 16,
    parameter int WIDTH = 4,
    localparam int SQN_W = robPkg::sqnWidth(LENGTH),
    localparam int IDX_W = $clog2(LENGTH)
) (
    input logic clk,
    input logic rst,
    input logic mispredTaken,
    input logic [SQN_W-1:0] mispredSqN,
    input logic [SQN_W-1:0] headSqN,
    input logic [robPkg::NAME_W-1:0] replayName [WIDTH],
    input logic [robPkg::TAG_W-1:0] replayTag [WIDTH],
    output logic replayActive,
    output logic [IDX_W-1:0] replayBase,
    output logic replayLaneValid [WIDTH],
    output logic [SQN_W-1:0] replaySqN [WIDTH],
    output logic [robPkg::NAME_W-1:0] replayNameOut [WIDTH],
    output logic [robPkg::TAG_W-1:0] replayTagOut [WIDTH]
);

    logic [SQN_W-1:0] iter;
    logic [SQN_W-1:0] endSqN;
    logic lastGroup;

    assign replayBase = iter[IDX_W-1:0];

    // Lanes up to and including the branch carry an op
    always_comb begin
        logic [SQN_W-1:0] seq;
        logic signed [SQN_W-1:0] dLane;
        logic signed [SQN_W-1:0] dLast;
        for (int i = 0; i < WIDTH; i++) begin
            seq = iter + SQN_W'(i);
            dLane = seq - endSqN;
            replaySqN[i] = seq;
            replayLaneValid[i] = replayActive && dLane <= 0;
            replayNameOut[i] = replayLaneValid[i] ? replayName[i] : '0;
            replayTagOut[i] = replayLaneValid[i] ? replayTag[i] : '0;
        end
        dLast = iter + SQN_W'(WIDTH - 1) - endSqN;
        lastGroup = dLast >= 0;
    end

    always_ff @(posedge clk) begin
        if (rst)
            replayActive <= 1'b0;
        else if (mispredTaken)
            replayActive <= 1'b1;
        else if (replayActive && lastGroup)
            replayActive <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (mispredTaken) begin
            iter <= headSqN;
            endSqN <= mispredSqN;
        end else if (replayActive) begin
            iter <= iter + SQN_W'(WIDTH);
        end
    end

endmodule

`default_nettype wire

/* hw/commitWindow.sv */
`default_nettype none
`timescale 1ns/1ns

module commitWindow #(
    parameter int LENGTH = 16,
    parameter int WIDTH = 4,
    localparam int SQN_W = robPkg::sqnWidth(LENGTH)
) (
    input logic clk,
    input logic rst,
    input logic headValid [WIDTH],
    input logic headExecuted [WIDTH],
    input logic [robPkg::FLAG_W-1:0] headFlags [WIDTH],
    input logic [robPkg::NAME_W-1:0] headName [WIDTH],
    input logic [robPkg::TAG_W-1:0] headTag [WIDTH],
    input logic mispredTaken,
    input logic replayActive,
    input logic replayLaneValid [WIDTH],
    input logic [robPkg::NAME_W-1:0] replayName [WIDTH],
    input logic [robPkg::TAG_W-1:0] replayTag [WIDTH],
    input logic [SQN_W-1:0] replaySqN [WIDTH],
    output logic [SQN_W-1:0] headSqN,
    output logic [SQN_W-1:0] curSqN,
    output logic [SQN_W-1:0] maxSqN,
    output logic retireMask [WIDTH],
    output logic comValid [WIDTH],
    output logic [SQN_W-1:0] comSqN [WIDTH],
    output logic [robPkg::NAME_W-1:0] comName [WIDTH],
    output logic [robPkg::TAG_W-1:0] comTag [WIDTH],
    output logic comIsBranch [WIDTH],
    output logic mispredFlush,
    output logic trapTaken,
    output logic [SQN_W-1:0] trapSqN,
    output logic halt
);

    logic stop;
    logic trapPend;
    logic trapPendBrk;
    logic [SQN_W-1:0] trapPendSqN;

    logic [SQN_W-1:0] retireCount;
    logic trapHit;
    logic trapHitBrk;
    logic [SQN_W-1:0] trapHitSqN;

    assign curSqN = headSqN;
    assign maxSqN = headSqN + SQN_W'(LENGTH - 1);

    // Retire the longest executed prefix with at most one flagged op
    always_comb begin
        logic blocked;
        logic flagSeen;
        blocked = stop || mispredTaken || replayActive;
        flagSeen = 1'b0;
        retireCount = '0;
        trapHit = 1'b0;
        trapHitBrk = 1'b0;
        trapHitSqN = headSqN;
        for (int i = 0; i < WIDTH; i++) begin
            retireMask[i] = 1'b0;
            if (!blocked && headValid[i] && headExecuted[i] &&
                (!flagSeen || headFlags[i] == robPkg::FLAGS_NONE)) begin
                retireMask[i] = 1'b1;
                retireCount = retireCount + SQN_W'(1);
                if (headFlags[i] != robPkg::FLAGS_NONE)
                    flagSeen = 1'b1;
                if (headFlags[i][1]) begin
                    // Nothing behind a trap may leave in the same group
                    blocked = 1'b1;
                    trapHit = 1'b1;
                    trapHitBrk = headFlags[i] == robPkg::FLAGS_BRK;
                    trapHitSqN = headSqN + SQN_W'(i);
                end
            end else begin
                blocked = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headSqN <= '0;
            stop <= 1'b0;
            trapPend <= 1'b0;
            trapTaken <= 1'b0;
            halt <= 1'b0;
            mispredFlush <= 1'b0;
            for (int i = 0; i < WIDTH; i++)
                comValid[i] <= 1'b0;
        end else begin
            headSqN <= headSqN + retireCount;
            trapTaken <= trapPend;
            halt <= trapPend && trapPendBrk;
            trapPend <= trapHit;
            // Hold retirement through the redirect cycle
            if (trapHit)
                stop <= 1'b1;
            else if (trapTaken)
                stop <= 1'b0;
            if (mispredTaken) begin
                mispredFlush <= 1'b0;
                for (int i = 0; i < WIDTH; i++)
                    comValid[i] <= 1'b0;
            end else if (replayActive) begin
                mispredFlush <= 1'b1;
                for (int i = 0; i < WIDTH; i++)
                    comValid[i] <= replayLaneValid[i];
            end else begin
                mispredFlush <= 1'b0;
                for (int i = 0; i < WIDTH; i++)
                    comValid[i] <= retireMask[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trapHit) begin
            trapPendSqN <= trapHitSqN;
            trapPendBrk <= trapHitBrk;
        end
        if (trapPend)
            trapSqN <= trapPendSqN;
        for (int i = 0; i < WIDTH; i++) begin
            if (replayActive) begin
                comSqN[i] <= replaySqN[i];
                comName[i] <= replayName[i];
                comTag[i] <= replayTag[i];
                comIsBranch[i] <= 1'b0;
            end else begin
                comSqN[i] <= headSqN + SQN_W'(i);
                // Excepting op writes to the discard register
                comName[i] <= (headFlags[i] == robPkg::FLAGS_EXCEPT) ? '0 : headName[i];
                comTag[i] <= headTag[i];
                comIsBranch[i] <= headFlags[i] == robPkg::FLAGS_BRANCH;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/robEntryFile.sv */
`default_nettype none
`timescale 1ns/1ns

module robEntryFile #(
    parameter int LENGTH = 16,
    parameter int WIDTH = 4,
    parameter int WIDTH_WB = 2,
    localparam int SQN_W = robPkg::sqnWidth(LENGTH),
    localparam int IDX_W = $clog2(LENGTH)
) (
    input logic clk,
    input logic rst,
    input logic dispValid [WIDTH],
    input logic [SQN_W-1:0] dispSqN [WIDTH],
    input logic [robPkg::NAME_W-1:0] dispName [WIDTH],
    input logic [robPkg::TAG_W-1:0] dispTag [WIDTH],
    input logic dispPreExec [WIDTH],
    input logic wbValid [WIDTH_WB],
    input logic [SQN_W-1:0] wbSqN [WIDTH_WB],
    input logic [robPkg::FLAG_W-1:0] wbFlags [WIDTH_WB],
    input logic mispredTaken,
    input logic [SQN_W-1:0] mispredSqN,
    input logic trapTaken,
    input logic [SQN_W-1:0] trapSqN,
    input logic [SQN_W-1:0] headSqN,
    input logic [IDX_W-1:0] replayBase,
    input logic retireMask [WIDTH],
    output logic headValid [WIDTH],
    output logic headExecuted [WIDTH],
    output logic [robPkg::FLAG_W-1:0] headFlags [WIDTH],
    output logic [robPkg::NAME_W-1:0] headName [WIDTH],
    output logic [robPkg::TAG_W-1:0] headTag [WIDTH],
    output logic [robPkg::NAME_W-1:0] replayName [WIDTH],
    output logic [robPkg::TAG_W-1:0] replayTag [WIDTH]
);

    logic entValid [LENGTH];
    logic entExec [LENGTH];
    logic entGen [LENGTH];
    logic [robPkg::FLAG_W-1:0] entFlags [LENGTH];
    logic [robPkg::NAME_W-1:0] entName [LENGTH];
    logic [robPkg::TAG_W-1:0] entTag [LENGTH];

    logic sortValid [WIDTH];
    logic [SQN_W-1:0] sortSqN [WIDTH];
    logic [robPkg::NAME_W-1:0] sortName [WIDTH];
    logic [robPkg::TAG_W-1:0] sortTag [WIDTH];
    logic sortPreExec [WIDTH];

    logic squash [LENGTH];
    logic wbKeep [WIDTH_WB];
    logic [IDX_W-1:0] headIdx [WIDTH];

    // Each lane owns the entries whose low sqN bits equal its lane number
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            sortValid[i] = 1'b0;
            sortSqN[i] = '0;
            sortName[i] = '0;
            sortTag[i] = '0;
            sortPreExec[i] = 1'b0;
            for (int j = 0; j < WIDTH; j++) begin
                if (dispValid[j] &&
                    (dispSqN[j][IDX_W-1:0] & IDX_W'(WIDTH - 1)) == IDX_W'(i)) begin
                    sortValid[i] = 1'b1;
                    sortSqN[i] = dispSqN[j];
                    sortName[i] = dispName[j];
                    sortTag[i] = dispTag[j];
                    sortPreExec[i] = dispPreExec[j];
                end
            end
        end
    end

    // Younger than the redirect point means a positive wrapped difference
    always_comb begin
        logic [SQN_W-1:0] seq;
        logic signed [SQN_W-1:0] dMis;
        logic signed [SQN_W-1:0] dTrap;
        for (int k = 0; k < LENGTH; k++) begin
            seq = {entGen[k], IDX_W'(k)};
            dMis = seq - mispredSqN;
            dTrap = seq - trapSqN;
            squash[k] = (mispredTaken && dMis > 0) || (trapTaken && dTrap > 0);
        end
    end

    always_comb begin
        logic signed [SQN_W-1:0] dWb;
        for (int j = 0; j < WIDTH_WB; j++) begin
            dWb = wbSqN[j] - mispredSqN;
            wbKeep[j] = wbValid[j] && (!mispredTaken || dWb <= 0);
        end
    end

    // Head window, an entry from an older pass does not count as valid
    always_comb begin
        logic [SQN_W-1:0] seq;
        logic [IDX_W-1:0] rIdx;
        for (int i = 0; i < WIDTH; i++) begin
            seq = headSqN + SQN_W'(i);
            headIdx[i] = seq[IDX_W-1:0];
            headValid[i] = entValid[headIdx[i]] && (entGen[headIdx[i]] == seq[SQN_W-1]);
            headExecuted[i] = entExec[headIdx[i]];
            headFlags[i] = entFlags[headIdx[i]];
            headName[i] = entName[headIdx[i]];
            headTag[i] = entTag[headIdx[i]];
            rIdx = replayBase + IDX_W'(i);
            replayName[i] = entName[rIdx];
            replayTag[i] = entTag[rIdx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < LENGTH; k++) begin
                entValid[k] <= 1'b0;
                entExec[k] <= 1'b0;
            end
        end else begin
            for (int k = 0; k < LENGTH; k++) begin
                if (squash[k]) begin
                    entValid[k] <= 1'b0;
                    entExec[k] <= 1'b0;
                end
            end
            for (int i = 0; i < WIDTH; i++) begin
                if (retireMask[i]) begin
                    entValid[headIdx[i]] <= 1'b0;
                    entExec[headIdx[i]] <= 1'b0;
                end
            end
            for (int i = 0; i < WIDTH; i++) begin
                if (sortValid[i] && !mispredTaken) begin
                    entValid[sortSqN[i][IDX_W-1:0]] <= 1'b1;
                    entExec[sortSqN[i][IDX_W-1:0]] <= sortPreExec[i];
                end
            end
            for (int j = 0; j < WIDTH_WB; j++) begin
                if (wbKeep[j]) begin
                    entExec[wbSqN[j][IDX_W-1:0]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (sortValid[i] && !mispredTaken) begin
                entName[sortSqN[i][IDX_W-1:0]] <= sortName[i];
                entTag[sortSqN[i][IDX_W-1:0]] <= sortTag[i];
                entGen[sortSqN[i][IDX_W-1:0]] <= sortSqN[i][SQN_W-1];
                entFlags[sortSqN[i][IDX_W-1:0]] <= robPkg::FLAGS_NONE;
            end
        end
        for (int j = 0; j < WIDTH_WB; j++) begin
            if (wbKeep[j]) begin
                entFlags[wbSqN[j][IDX_W-1:0]] <= wbFlags[j];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/robPkg.sv */
`default_nettype none

package robPkg;

    // Result flags from writeback, bit 1 marks a trapping op
    localparam int FLAG_W = 2;

    localparam logic [FLAG_W-1:0] FLAGS_NONE = 2'd0;
    localparam logic [FLAG_W-1:0] FLAGS_BRANCH = 2'd1;
    localparam logic [FLAG_W-1:0] FLAGS_EXCEPT = 2'd2;
    localparam logic [FLAG_W-1:0] FLAGS_BRK = 2'd3;

    // Architectural register name, name 0 discards the result
    localparam int NAME_W = 5;

    // Physical register tag
    localparam int TAG_W = 6;

    // Sequence number width for a buffer of the given length.
    // The extra top bit separates two passes over the same entry
    function automatic int sqnWidth(input int length);
        int w;
        w = $clog2(length) + 1;
        return w;
    endfunction

endpackage

`default_nettype wire
